/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_renametable
FILELIST  := renametable.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* common/rename_cfg_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Rename block configuration
////////////////////////////////////////////////////////////////////////////

package rename_cfg_pkg;

    // group sizes seen by the front end and by commit.
    localparam int RENAME_WIDTH = 2;                   // instructions renamed per cycle.
    localparam int COMMIT_WIDTH = 2;                   // instructions committed per cycle.
    localparam int NUMSRCS_INT  = 2;                   // integer source operands per op.

    // register file sizes.
    localparam int NUM_LREGS = 32;                     // architectural integer registers.
    localparam int NUM_PREGS = 64;                     // physical integer registers.

    // Derived widths. The count needs one extra bit to hold a full ring.
    localparam int ILR_IDX_W = $clog2(NUM_LREGS);      // logical index width.
    localparam int IPR_IDX_W = $clog2(NUM_PREGS);      // physical index width.
    localparam int FL_CNT_W  = $clog2(NUM_PREGS) + 1;  // holds 0 up to NUM_PREGS.

    ////////////////////////////////////////////////////////////////////////////
    // Index types
    ////////////////////////////////////////////////////////////////////////////

    // logical integer register index.
    typedef logic [ILR_IDX_W-1:0] ilr_idx_t;

    // physical integer register index.
    typedef logic [IPR_IDX_W-1:0] ipr_idx_t;

    // Free list occupancy and ring pointer type.
    // The low bits address the ring and the top bit marks the lap.
    typedef logic [FL_CNT_W-1:0] fl_cnt_t;

endpackage

`default_nettype wire

/* common/rename_msg_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Messages between front end, rename and commit
////////////////////////////////////////////////////////////////////////////

package rename_msg_pkg;

    import rename_cfg_pkg::*;

    // One instruction offered for rename.
    // lrd is only meaningful when has_rd is set.
    typedef struct packed {
        logic                         has_rd;  // instruction writes a destination.
        ilr_idx_t                     lrd;     // logical destination.
        ilr_idx_t [NUMSRCS_INT-1:0]   lrs;     // logical sources.
    } rename_req_t;

    // The renamed form of one instruction.
    typedef struct packed {
        ipr_idx_t                     prd;       // newly allocated destination.
        ipr_idx_t                     prev_prd;  // mapping replaced by prd.
        ipr_idx_t [NUMSRCS_INT-1:0]   prs;       // physical sources.
    } rename_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Commit side
    ////////////////////////////////////////////////////////////////////////////

    // One retiring instruction as seen by the rename block.
    // prev_prd goes back to the free list once the commit is taken.
    typedef struct packed {
        logic                         has_rd;    // instruction wrote a destination.
        ilr_idx_t                     lrd;       // logical destination.
        ipr_idx_t                     prd;       // physical destination now committed.
        ipr_idx_t                     prev_prd;  // older mapping to release.
    } commit_info_t;

endpackage

`default_nettype wire

/* renametable.f */
common/rename_cfg_pkg.sv
common/rename_msg_pkg.sv
renametable/rat_map.sv
renametable/freelist.sv
renametable/renametable.sv
testbench/tb_renametable.sv

/* renametable/freelist.sv */
`timescale 1ns/1ps
`default_nettype none

module freelist
    import rename_cfg_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 i_arst_n,

    // allocation at rename.
    input  wire [RENAME_WIDTH-1:0]              i_alloc_req,
    output ipr_idx_t [RENAME_WIDTH-1:0]         o_alloc_prd,
    output logic                                o_can_alloc,

    // release at commit.
    input  wire [COMMIT_WIDTH-1:0]              i_dealloc_req,
    input  wire ipr_idx_t [COMMIT_WIDTH-1:0]    i_dealloc_prd,

    input  wire                                 i_squash_vld
);

    ipr_idx_t   ring_q [NUM_PREGS];

    // Pointers carry one lap bit above the ring index.
    fl_cnt_t    spec_head_q;
    fl_cnt_t    commit_head_q;
    fl_cnt_t    tail_q;

    fl_cnt_t    alloc_ofs [RENAME_WIDTH];
    fl_cnt_t    alloc_cnt;
    fl_cnt_t    dealloc_ofs [COMMIT_WIDTH];
    fl_cnt_t    dealloc_cnt;
    fl_cnt_t    free_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Slot offsets
    ////////////////////////////////////////////////////////////////////////////

    // each requesting slot takes the next entry; idle slots are skipped.
    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            alloc_ofs[i] = alloc_cnt;
            alloc_cnt    = alloc_cnt + fl_cnt_t'(i_alloc_req[i]);
        end
    end

    always_comb begin
        dealloc_cnt = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            dealloc_ofs[i] = dealloc_cnt;
            dealloc_cnt    = dealloc_cnt + fl_cnt_t'(i_dealloc_req[i]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Allocation outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_alloc_prd[i] = ring_q[ipr_idx_t'(spec_head_q + alloc_ofs[i])];
        end
    end

    assign free_cnt    = tail_q - spec_head_q;  // lap bit keeps a full ring distinct from empty.
    assign o_can_alloc = (free_cnt >= fl_cnt_t'(RENAME_WIDTH));

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            spec_head_q   <= '0;
            commit_head_q <= '0;
            tail_q        <= fl_cnt_t'(NUM_PREGS - NUM_LREGS);  // registers above the identity map.
        end else begin
            // every committed destination consumed one entry at rename.
            commit_head_q <= commit_head_q + dealloc_cnt;
            tail_q        <= tail_q + dealloc_cnt;
            if (i_squash_vld) begin
                spec_head_q <= commit_head_q + dealloc_cnt;  // drop all speculative allocations.
            end else begin
                spec_head_q <= spec_head_q + alloc_cnt;
            end
        end
    end

    // The ring starts out holding NUM_LREGS upward.
    // Entries past the tail are overwritten before they are read.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                ring_q[i] <= ipr_idx_t'(i + NUM_LREGS);
            end
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (i_dealloc_req[i]) begin
                    ring_q[ipr_idx_t'(tail_q + dealloc_ofs[i])] <= i_dealloc_prd[i];  // slot order.
                end
            end
        end
    end

endmodule

`default_nettype wire

/* renametable/rat_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_map
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
#(
    parameter type lr_idx_t = ilr_idx_t,
    parameter type pr_idx_t = ipr_idx_t
) (
    input  wire                                  clk,
    input  wire                                  i_arst_n,

    // accepted group and its allocated destinations.
    input  wire [RENAME_WIDTH-1:0]               i_alloc_vld,
    input  wire rename_req_t [RENAME_WIDTH-1:0]  i_rename_req,
    input  wire pr_idx_t [RENAME_WIDTH-1:0]      i_alloc_prd,
    output rename_rsp_t [RENAME_WIDTH-1:0]       o_rename_rsp,

    // commit and squash.
    input  wire [COMMIT_WIDTH-1:0]               i_commit_rd_vld,
    input  wire commit_info_t [COMMIT_WIDTH-1:0] i_commit_info,
    input  wire                                  i_squash_vld,
    output pr_idx_t [COMMIT_WIDTH-1:0]           o_dealloc_prd,

    output pr_idx_t [NUM_LREGS-1:0]              o_spec_map
);

    pr_idx_t [NUM_LREGS-1:0]    spec_map_q;
    pr_idx_t [NUM_LREGS-1:0]    spec_map_d;
    pr_idx_t [NUM_LREGS-1:0]    commit_map_q;
    pr_idx_t [NUM_LREGS-1:0]    commit_map_d;

    lr_idx_t                    ren_lrd [RENAME_WIDTH];
    lr_idx_t                    ren_lrs [RENAME_WIDTH][NUMSRCS_INT];
    lr_idx_t                    cmt_lrd [COMMIT_WIDTH];

    // logical indices in the table's own index type.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            ren_lrd[i] = lr_idx_t'(i_rename_req[i].lrd);
            for (int s = 0; s < NUMSRCS_INT; s++) begin
                ren_lrs[i][s] = lr_idx_t'(i_rename_req[i].lrs[s]);
            end
        end
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            cmt_lrd[i] = lr_idx_t'(i_commit_info[i].lrd);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lookup with intra-group bypass
    ////////////////////////////////////////////////////////////////////////////

    // Earlier slots are scanned in order, so the last matching writer wins.
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_rename_rsp[i].prd      = i_alloc_prd[i];
            o_rename_rsp[i].prev_prd = spec_map_q[ren_lrd[i]];
            for (int s = 0; s < NUMSRCS_INT; s++) begin
                o_rename_rsp[i].prs[s] = spec_map_q[ren_lrs[i][s]];
            end
            for (int j = 0; j < i; j++) begin
                if (i_alloc_vld[j] && (ren_lrd[j] == ren_lrd[i])) begin
                    o_rename_rsp[i].prev_prd = i_alloc_prd[j];  // older slot renamed it first.
                end
                for (int s = 0; s < NUMSRCS_INT; s++) begin
                    if (i_alloc_vld[j] && (ren_lrd[j] == ren_lrs[i][s])) begin
                        o_rename_rsp[i].prs[s] = i_alloc_prd[j];  // read after write in group.
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state of both tables
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        commit_map_d = commit_map_q;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i_commit_rd_vld[i]) begin
                commit_map_d[cmt_lrd[i]] = i_commit_info[i].prd;  // younger commit overwrites.
            end
        end
    end

    always_comb begin
        spec_map_d = spec_map_q;
        if (i_squash_vld) begin
            spec_map_d = commit_map_d;  // restore includes this cycle's commits.
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_alloc_vld[i]) begin
                    spec_map_d[ren_lrd[i]] = i_alloc_prd[i];
                end
            end
        end
    end

    // both tables come out of reset as the identity mapping.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                spec_map_q[i]   <= pr_idx_t'(i);
                commit_map_q[i] <= pr_idx_t'(i);
            end
        end else begin
            spec_map_q   <= spec_map_d;
            commit_map_q <= commit_map_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Release and debug view
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            o_dealloc_prd[i] = i_commit_info[i].prev_prd;  // no longer reachable once committed.
        end
    end

    assign o_spec_map = spec_map_q;

endmodule

`default_nettype wire

/* renametable/renametable.sv */
`timescale 1ns/1ps
`default_nettype none

module renametable
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 i_arst_n,

    // rename group from the front end.
    input  wire                                 i_rename_vld,
    input  wire rename_req_t [RENAME_WIDTH-1:0] i_rename_req,
    output rename_rsp_t [RENAME_WIDTH-1:0]      o_rename_rsp,
    output logic                                o_can_rename,

    // retire and squash.
    input  wire [COMMIT_WIDTH-1:0]              i_commit_vld,
    input  wire commit_info_t [COMMIT_WIDTH-1:0] i_commit_info,
    input  wire                                 i_squash_vld,

    output ipr_idx_t [NUM_LREGS-1:0]            o_spec_map
);

    logic                               can_alloc;
    logic                               rename_accept;
    logic [RENAME_WIDTH-1:0]            alloc_vld;
    logic [COMMIT_WIDTH-1:0]            commit_rd_vld;
    ipr_idx_t [RENAME_WIDTH-1:0]        alloc_prd;
    ipr_idx_t [COMMIT_WIDTH-1:0]        dealloc_prd;

    ////////////////////////////////////////////////////////////////////////////
    // Accept and destination masks
    ////////////////////////////////////////////////////////////////////////////

    assign o_can_rename  = can_alloc;
    // a squash wins over a new group so the restored map is not disturbed.
    assign rename_accept = i_rename_vld & can_alloc & ~i_squash_vld;

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            alloc_vld[i] = rename_accept & i_rename_req[i].has_rd;  // slot takes a free entry.
        end
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_rd_vld[i] = i_commit_vld[i] & i_commit_info[i].has_rd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Map tables and free list
    ////////////////////////////////////////////////////////////////////////////

    rat_map #(
        .lr_idx_t        ( ilr_idx_t      ),
        .pr_idx_t        ( ipr_idx_t      )
    ) u_rat_map (
        .clk             ( clk            ),
        .i_arst_n        ( i_arst_n       ),
        .i_alloc_vld     ( alloc_vld      ),
        .i_rename_req    ( i_rename_req   ),
        .i_alloc_prd     ( alloc_prd      ),
        .o_rename_rsp    ( o_rename_rsp   ),
        .i_commit_rd_vld ( commit_rd_vld  ),
        .i_commit_info   ( i_commit_info  ),
        .i_squash_vld    ( i_squash_vld   ),
        .o_dealloc_prd   ( dealloc_prd    ),
        .o_spec_map      ( o_spec_map     )
    );

    // the same mask frees prev_prd and moves the committed head.
    freelist u_freelist (
        .clk             ( clk            ),
        .i_arst_n        ( i_arst_n       ),
        .i_alloc_req     ( alloc_vld      ),
        .o_alloc_prd     ( alloc_prd      ),
        .o_can_alloc     ( can_alloc      ),
        .i_dealloc_req   ( commit_rd_vld  ),
        .i_dealloc_prd   ( dealloc_prd    ),
        .i_squash_vld    ( i_squash_vld   )
    );

endmodule

`default_nettype wire

/* testbench/tb_renametable.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_renametable
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
();

    // rough length of each phase in clock cycles.
    localparam int RESET_LEN   = 6;
    localparam int TEST_LEN    = 2 + 4 + 10 + 20 + 30;
    localparam int TIMEOUT_CYC = 3 * (RESET_LEN + TEST_LEN);

    logic                               clk = 1'b0;
    logic                               i_arst_n;
    logic                               i_rename_vld;
    rename_req_t [RENAME_WIDTH-1:0]     i_rename_req;
    rename_rsp_t [RENAME_WIDTH-1:0]     o_rename_rsp;
    logic                               o_can_rename;
    logic [COMMIT_WIDTH-1:0]            i_commit_vld;
    commit_info_t [COMMIT_WIDTH-1:0]    i_commit_info;
    logic                               i_squash_vld;
    ipr_idx_t [NUM_LREGS-1:0]           o_spec_map;

    // reference model state.
    ipr_idx_t       model_spec [NUM_LREGS];
    ipr_idx_t       model_commit [NUM_LREGS];
    ipr_idx_t       free_q [$];      // entries the speculative head will hand out next.
    ipr_idx_t       inflight_q [$];  // allocated but not yet committed, oldest first.
    commit_info_t   pending_q [$];   // renamed instructions waiting to retire.

    logic [31:0]    lfsr_q = 32'h25f9;
    int             err_cnt = 0;
    int             pass_cnt = 0;
    int             fail_cnt = 0;
    int             cycle_cnt = 0;

    always #2 clk = ~clk;

    renametable DUT (
        .clk           ( clk           ),
        .i_arst_n      ( i_arst_n      ),
        .i_rename_vld  ( i_rename_vld  ),
        .i_rename_req  ( i_rename_req  ),
        .o_rename_rsp  ( o_rename_rsp  ),
        .o_can_rename  ( o_can_rename  ),
        .i_commit_vld  ( i_commit_vld  ),
        .i_commit_info ( i_commit_info ),
        .i_squash_vld  ( i_squash_vld  ),
        .o_spec_map    ( o_spec_map    )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // taps 32, 22, 2 and 1; one step per bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic rename_req_t random_req(input logic force_rd);
        rename_req_t r;
        r.has_rd = force_rd | (take_bits(2) != 32'd0);  // three in four write a register.
        r.lrd    = ilr_idx_t'(take_bits(ILR_IDX_W));
        for (int s = 0; s < NUMSRCS_INT; s++) begin
            r.lrs[s] = ilr_idx_t'(take_bits(ILR_IDX_W));
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_cnt++;
        $display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic check_spec_map();
        for (int i = 0; i < NUM_LREGS; i++) begin
            if (o_spec_map[i] !== model_spec[i]) begin
                report_mismatch($sformatf("o_spec_map[%0d]", i), 32'(model_spec[i]),
                                32'(o_spec_map[i]));
            end
        end
    endtask

    task automatic check_can_rename();
        logic exp_can;
        exp_can = (free_q.size() >= RENAME_WIDTH);
        if (o_can_rename !== exp_can) begin
            report_mismatch("o_can_rename", 32'(exp_can), 32'(o_can_rename));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus actions, each entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic rename_group(input rename_req_t req0, input rename_req_t req1);
        rename_req_t  req [RENAME_WIDTH];
        ipr_idx_t     tmp_map [NUM_LREGS];
        ipr_idx_t     exp_prd;
        ipr_idx_t     exp_prev;
        ipr_idx_t     exp_prs;
        logic         accept;
        commit_info_t ci;
        req[0]          = req0;
        req[1]          = req1;
        accept          = (free_q.size() >= RENAME_WIDTH);
        tmp_map         = model_spec;
        i_rename_vld    = 1'b1;
        i_rename_req[0] = req0;
        i_rename_req[1] = req1;
        #1;
        check_can_rename();
        if (accept) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                for (int s = 0; s < NUMSRCS_INT; s++) begin
                    exp_prs = tmp_map[req[i].lrs[s]];  // earlier slots already applied.
                    if (o_rename_rsp[i].prs[s] !== exp_prs) begin
                        report_mismatch($sformatf("o_rename_rsp[%0d].prs[%0d]", i, s),
                                        32'(exp_prs), 32'(o_rename_rsp[i].prs[s]));
                    end
                end
                exp_prd  = '0;
                exp_prev = '0;
                if (req[i].has_rd) begin
                    exp_prev = tmp_map[req[i].lrd];
                    exp_prd  = free_q.pop_front();
                    if (o_rename_rsp[i].prev_prd !== exp_prev) begin
                        report_mismatch($sformatf("o_rename_rsp[%0d].prev_prd", i),
                                        32'(exp_prev), 32'(o_rename_rsp[i].prev_prd));
                    end
                    if (o_rename_rsp[i].prd !== exp_prd) begin
                        report_mismatch($sformatf("o_rename_rsp[%0d].prd", i),
                                        32'(exp_prd), 32'(o_rename_rsp[i].prd));
                    end
                    tmp_map[req[i].lrd] = exp_prd;
                    inflight_q.push_back(exp_prd);
                end
                ci.has_rd   = req[i].has_rd;
                ci.lrd      = req[i].lrd;
                ci.prd      = exp_prd;
                ci.prev_prd = exp_prev;
                pending_q.push_back(ci);
            end
            model_spec = tmp_map;
        end
        @(negedge clk);
        i_rename_vld = 1'b0;
        check_spec_map();  // new mappings are visible one cycle later.
    endtask

    task automatic commit_group(input int n);
        commit_info_t ci;
        i_commit_vld = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            i_commit_info[i] = '0;
            if ((i < n) && (pending_q.size() > 0)) begin
                ci               = pending_q.pop_front();
                i_commit_vld[i]  = 1'b1;
                i_commit_info[i] = ci;
                if (ci.has_rd) begin
                    model_commit[ci.lrd] = ci.prd;
                    free_q.push_back(ci.prev_prd);  // tail order follows slot order.
                    inflight_q.delete(0);
                end
            end
        end
        @(negedge clk);
        i_commit_vld = '0;
        check_can_rename();
    endtask

    task automatic squash_group();
        i_squash_vld = 1'b1;
        model_spec   = model_commit;
        // uncommitted allocations return ahead of the free entries.
        while (inflight_q.size() > 0) begin
            free_q.push_front(inflight_q.pop_back());
        end
        pending_q.delete();
        @(negedge clk);
        i_squash_vld = 1'b0;
        check_spec_map();
        check_can_rename();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int err_before;
        err_before = err_cnt;
        check_spec_map();
        if (o_can_rename !== 1'b1) begin
            report_mismatch("o_can_rename", 32'd1, 32'(o_can_rename));
        end
        end_test("reset_state", err_before);
    endtask

    task automatic test_rename_groups();
        int          err_before;
        rename_req_t r0;
        rename_req_t r1;
        err_before = err_cnt;
        for (int g = 0; g < 3; g++) begin
            rename_group(random_req(1'b0), random_req(1'b0));
        end
        // second slot reads and rewrites the first slot's destination.
        r0        = random_req(1'b1);
        r1        = random_req(1'b1);
        r1.lrd    = r0.lrd;
        r1.lrs[0] = r0.lrd;
        rename_group(r0, r1);
        end_test("rename_groups", err_before);
    endtask

    task automatic test_commit_squash();
        int err_before;
        err_before = err_cnt;
        rename_group(random_req(1'b1), random_req(1'b1));
        while (pending_q.size() > RENAME_WIDTH) begin
            if (pending_q.size() - RENAME_WIDTH >= COMMIT_WIDTH) begin
                commit_group(COMMIT_WIDTH);
            end else begin
                commit_group(1);
            end
        end
        squash_group();
        rename_group(random_req(1'b1), random_req(1'b1));  // reuses the squashed entries.
        end_test("commit_squash", err_before);
    endtask

    task automatic test_fill_list();
        int err_before;
        err_before = err_cnt;
        while (free_q.size() >= RENAME_WIDTH) begin
            rename_group(random_req(1'b1), random_req(1'b1));
        end
        if (o_can_rename !== 1'b0) begin
            report_mismatch("o_can_rename", 32'd0, 32'(o_can_rename));
        end
        rename_group(random_req(1'b1), random_req(1'b1));  // refused, map must hold.
        end_test("fill_list", err_before);
    endtask

    task automatic test_release();
        int err_before;
        err_before = err_cnt;
        while (pending_q.size() > 0) begin
            commit_group(COMMIT_WIDTH);
        end
        for (int g = 0; g < 6; g++) begin
            rename_group(random_req(1'b1), random_req(1'b1));
        end
        end_test("release", err_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        i_arst_n      = 1'b0;
        i_rename_vld  = 1'b0;
        i_rename_req  = '0;
        i_commit_vld  = '0;
        i_commit_info = '0;
        i_squash_vld  = 1'b0;
        for (int i = 0; i < NUM_LREGS; i++) begin
            model_spec[i]   = ipr_idx_t'(i);
            model_commit[i] = ipr_idx_t'(i);
            free_q.push_back(ipr_idx_t'(i + NUM_LREGS));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        test_reset_state();
        test_rename_groups();
        test_commit_squash();
        test_fill_list();
        test_release();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
